/* rtl/rename_defines.svh */
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Architectural register file size
`define NUM_REGS    32
`define REG_ADDR_W  5

// Tag zero means the register is not renamed
`define TAG_W       6

`define DATA_W      32

// Must stay below 2**TAG_W so every slot has a nonzero tag
`define ROB_DEPTH   16

// Hardwired zero register
`define ZERO_REG    0

`endif

/* rtl/rename_pkg.sv */
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    // Architectural register number
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Reorder-buffer tag, slot index plus one
    typedef logic [`TAG_W-1:0] tag_t;

    // Register value
    typedef logic [`DATA_W-1:0] data_t;

    // Life cycle of a reorder-buffer slot
    typedef enum logic [1:0] {
        ROB_FREE   = 2'd0, // Slot unused
        ROB_ISSUED = 2'd1, // Allocated, waiting for result
        ROB_DONE   = 2'd2  // Result written, waiting to retire
    } rob_state_e;

endpackage

`default_nettype wire

/* rtl/rename_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

// Result broadcast from the execution side
interface cdb_if;
    import rename_pkg::*;

    logic  valid;
    tag_t  tag;   // Tag of the completing instruction
    data_t value; // Its result

    modport listener (
        input valid,
        input tag,
        input value
    );
endinterface

// In-order commit of the oldest reorder-buffer entry
interface retire_if;
    import rename_pkg::*;

    logic      valid;
    reg_addr_t dest;  // Architectural destination
    tag_t      tag;   // Tag being released
    data_t     value; // Committed value

    modport source (
        output valid,
        output dest,
        output tag,
        output value
    );

    modport sink (
        input valid,
        input dest,
        input tag,
        input value
    );
endinterface

`default_nettype wire

/* rtl/map_table.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module map_table (
    input  logic                clock,
    input  logic                reset,
    input  rename_pkg::reg_addr_t rs1_addr,
    input  rename_pkg::reg_addr_t rs2_addr,
    input  rename_pkg::reg_addr_t dest_addr,
    input  rename_pkg::tag_t    alloc_tag,   // Tag granted by the ROB
    input  logic                load_entry,  // High only when a slot is allocated
    output rename_pkg::tag_t    rs1_tag,
    output rename_pkg::tag_t    rs2_tag,
    output logic                rs1_ready,
    output logic                rs2_ready,
    cdb_if.listener             cdb,
    retire_if.sink              retire
);
    import rename_pkg::*;

    tag_t tags  [`NUM_REGS]; // Zero when the register file holds the value
    logic ready [`NUM_REGS]; // Result sits in the ROB

    logic retire_match;

    // Lookup sees state from before this cycle's edge
    always_comb begin
        rs1_tag   = tags[rs1_addr];
        rs1_ready = ready[rs1_addr];
        rs2_tag   = tags[rs2_addr];
        rs2_ready = ready[rs2_addr];
    end

    // Only clear when the mapping still names the retiring instruction
    assign retire_match = retire.valid && (tags[retire.dest] == retire.tag);

    // Later assignments win: retire clear, then CDB set, then dispatch load
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                tags[i]  <= '0;
                ready[i] <= 1'b0;
            end
        end else begin
            if (retire_match) begin
                tags[retire.dest]  <= '0;
                ready[retire.dest] <= 1'b0;
            end

            if (cdb.valid) begin
                // Associative compare against every entry
                for (int i = 0; i < `NUM_REGS; i++) begin
                    if ((tags[i] != '0) && (tags[i] == cdb.tag)) begin
                        ready[i] <= 1'b1;
                    end
                end
            end

            if (load_entry && (dest_addr != reg_addr_t'(`ZERO_REG))) begin
                tags[dest_addr]  <= alloc_tag; // New producer
                ready[dest_addr] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rename_pkg::reg_addr_t dest_addr,
    output rename_pkg::tag_t      alloc_tag,
    output logic                  load_entry,
    output logic                  dispatch_stall,
    cdb_if.listener               cdb,
    retire_if.source              retire
);
    import rename_pkg::*;

    localparam int IDX_W = $clog2(`ROB_DEPTH);
    localparam int CNT_W = IDX_W + 1;

    rob_state_e state [`ROB_DEPTH];
    reg_addr_t  dest  [`ROB_DEPTH]; // Payload, no reset
    data_t      value [`ROB_DEPTH];

    logic [IDX_W-1:0] head; // Oldest entry
    logic [IDX_W-1:0] tail; // Next slot to allocate
    logic [CNT_W-1:0] count;

    logic             head_done;
    tag_t             cdb_tag_minus_one;
    logic [IDX_W-1:0] cdb_slot;

    // Circular increment, safe for any depth
    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        logic [IDX_W-1:0] result;
        if (idx == IDX_W'(`ROB_DEPTH - 1)) begin
            result = '0;
        end else begin
            result = idx + 1'b1;
        end
        return result;
    endfunction

    assign dispatch_stall = (count == CNT_W'(`ROB_DEPTH));
    assign load_entry     = dispatch_valid && !dispatch_stall;
    assign alloc_tag      = `TAG_W'(tail) + `TAG_W'(1); // Tag zero is reserved

    // Tag n lives in slot n-1
    assign cdb_tag_minus_one = cdb.tag - `TAG_W'(1);
    assign cdb_slot          = cdb_tag_minus_one[IDX_W-1:0];

    // Head retires as soon as its result is in
    assign head_done    = (state[head] == ROB_DONE);
    assign retire.valid = head_done;
    assign retire.dest  = dest[head];
    assign retire.tag   = `TAG_W'(head) + `TAG_W'(1);
    assign retire.value = value[head];

    // Slot states and pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state[i] <= ROB_FREE;
            end
        end else begin
            if (load_entry) begin
                state[tail] <= ROB_ISSUED;
                tail        <= next_idx(tail);
            end

            if (cdb.valid) begin
                state[cdb_slot] <= ROB_DONE; // Bus only names issued slots
            end

            if (head_done) begin
                state[head] <= ROB_FREE;
                head        <= next_idx(head);
            end

            // Allocation and release may happen together
            case ({load_entry, head_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Destination and result storage
    always_ff @(posedge clock) begin
        if (load_entry) begin
            dest[tail] <= dest_addr;
        end
        if (cdb.valid) begin
            value[cdb_slot] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

/* rtl/arch_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module arch_reg_file (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::reg_addr_t rs1_addr,
    input  rename_pkg::reg_addr_t rs2_addr,
    output rename_pkg::data_t     rs1_value,
    output rename_pkg::data_t     rs2_value,
    retire_if.sink                retire
);
    import rename_pkg::*;

    data_t regs [`NUM_REGS]; // Committed state

    logic write_en;

    // Writes to register zero are dropped
    assign write_en = retire.valid && (retire.dest != reg_addr_t'(`ZERO_REG));

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[retire.dest] <= retire.value;
        end
    end

    // No bypass, a same-cycle retire shows up next cycle
    always_comb begin
        if (rs1_addr == reg_addr_t'(`ZERO_REG)) begin
            rs1_value = '0;
        end else begin
            rs1_value = regs[rs1_addr];
        end

        if (rs2_addr == reg_addr_t'(`ZERO_REG)) begin
            rs2_value = '0;
        end else begin
            rs2_value = regs[rs2_addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/rename_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  dispatch_valid,
    input  rename_pkg::reg_addr_t rs1_addr,
    input  rename_pkg::reg_addr_t rs2_addr,
    input  rename_pkg::reg_addr_t dest_addr,
    input  logic                  cdb_valid,
    input  rename_pkg::tag_t      cdb_tag,
    input  rename_pkg::data_t     cdb_value,
    output logic                  dispatch_stall,
    output rename_pkg::tag_t      dest_tag,
    output rename_pkg::tag_t      rs1_tag,
    output rename_pkg::tag_t      rs2_tag,
    output logic                  rs1_ready,
    output logic                  rs2_ready,
    output rename_pkg::data_t     rs1_value,
    output rename_pkg::data_t     rs2_value,
    output logic                  retire_valid,
    output rename_pkg::reg_addr_t retire_dest,
    output rename_pkg::data_t     retire_value
);
    import rename_pkg::*;

    tag_t alloc_tag;  // Tag for the dispatching destination
    logic load_entry; // Slot actually allocated this cycle

    cdb_if    cdb_bus ();
    retire_if retire_bus ();

    // Result bus from the plain inputs
    assign cdb_bus.valid = cdb_valid;
    assign cdb_bus.tag   = cdb_tag;
    assign cdb_bus.value = cdb_value;

    assign dest_tag     = alloc_tag;
    assign retire_valid = retire_bus.valid;
    assign retire_dest  = retire_bus.dest;
    assign retire_value = retire_bus.value;

    map_table u_map_table (
        .clock      (clock),
        .reset      (reset),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .dest_addr  (dest_addr),
        .alloc_tag  (alloc_tag),
        .load_entry (load_entry),
        .rs1_tag    (rs1_tag),
        .rs2_tag    (rs2_tag),
        .rs1_ready  (rs1_ready),
        .rs2_ready  (rs2_ready),
        .cdb        (cdb_bus.listener),
        .retire     (retire_bus.sink)
    );

    reorder_buffer u_reorder_buffer (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dest_addr      (dest_addr),
        .alloc_tag      (alloc_tag),
        .load_entry     (load_entry),
        .dispatch_stall (dispatch_stall),
        .cdb            (cdb_bus.listener),
        .retire         (retire_bus.source)
    );

    arch_reg_file u_arch_reg_file (
        .clock     (clock),
        .reset     (reset),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .retire    (retire_bus.sink)
    );

endmodule

`default_nettype wire

/* tb/rename_core_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_core_assertions (
    input logic                  clock,
    input logic                  reset,
    input logic                  retire_valid,
    input logic                  dispatch_stall,
    input rename_pkg::reg_addr_t retire_dest,
    input rename_pkg::data_t     retire_value,
    input logic                  cdb_valid,
    input rename_pkg::tag_t      cdb_tag
);
    import rename_pkg::*;

    int error_count = 0; // Failed assertions so far

    // Empty buffer during reset and in the cycle after it
    reset_idle: assert property (@(posedge clock)
        reset |=> (!retire_valid && !dispatch_stall))
        else begin
            error_count++;
            $error("retire_valid or dispatch_stall high around reset");
        end

    // Register zero only ever commits zero
    zero_reg_commit: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> ((retire_dest != reg_addr_t'(`ZERO_REG)) || (retire_value == '0)))
        else begin
            error_count++;
            $error("Nonzero value retired to register zero");
        end

    // Tag zero never names a slot
    cdb_tag_nonzero: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> (cdb_tag != '0))
        else begin
            error_count++;
            $error("Data bus broadcast with tag zero");
        end

endmodule

bind rename_core rename_core_assertions u_assertions (
    .clock          (clock),
    .reset          (reset),
    .retire_valid   (retire_valid),
    .dispatch_stall (dispatch_stall),
    .retire_dest    (retire_dest),
    .retire_value   (retire_value),
    .cdb_valid      (cdb_valid),
    .cdb_tag        (cdb_tag)
);

`default_nettype wire

/* tb/rename_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_core_tb;
    import rename_pkg::*;

    localparam int RESET_LIMIT = 20;
    localparam int DRAIN_LIMIT = 500;

    logic      clock;
    logic      reset;
    logic      dispatch_valid;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t dest_addr;
    logic      cdb_valid;
    tag_t      cdb_tag;
    data_t     cdb_value;
    logic      dispatch_stall;
    tag_t      dest_tag;
    tag_t      rs1_tag;
    tag_t      rs2_tag;
    logic      rs1_ready;
    logic      rs2_ready;
    data_t     rs1_value;
    data_t     rs2_value;
    logic      retire_valid;
    reg_addr_t retire_dest;
    data_t     retire_value;

    // Reference model state
    tag_t       m_tag   [`NUM_REGS];
    logic       m_ready [`NUM_REGS];
    data_t      m_regs  [`NUM_REGS];
    tag_t       m_queue [$];          // In-flight tags, oldest first
    rob_state_e m_state [`ROB_DEPTH];
    reg_addr_t  m_dest  [`ROB_DEPTH];
    data_t      m_value [`ROB_DEPTH];
    int         m_tail;

    // Predicted outputs for the current cycle
    logic      exp_stall;
    tag_t      exp_dest_tag;
    tag_t      exp_rs1_tag;
    tag_t      exp_rs2_tag;
    logic      exp_rs1_ready;
    logic      exp_rs2_ready;
    data_t     exp_rs1_value;
    data_t     exp_rs2_value;
    logic      exp_retire_valid;
    reg_addr_t exp_retire_dest;
    data_t     exp_retire_value;

    int   seed = 53;
    int   waited;
    logic check_en = 1'b0;
    logic held = 1'b0;        // Stalled instruction kept on the inputs
    int   stall_hits = 0;
    int   remap_kept = 0;
    int   zero_retires = 0;

    rename_core uut (.*);

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (5) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
    end

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else
            stop_with_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic void model_reset();
        for (int i = 0; i < `NUM_REGS; i++) begin
            m_tag[i]   = '0;
            m_ready[i] = 1'b0;
            m_regs[i]  = '0;
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            m_state[i] = ROB_FREE;
        end
        m_queue.delete();
        m_tail = 0;
    endfunction

    // Predicts this cycle's outputs, then applies the coming clock edge
    function automatic void model_step(input logic dv, input reg_addr_t r1,
                                       input reg_addr_t r2, input reg_addr_t d,
                                       input logic cv, input tag_t ct, input data_t cval);
        int head_slot;
        int cslot;
        head_slot = 0;
        exp_stall     = (m_queue.size() == `ROB_DEPTH);
        exp_dest_tag  = tag_t'(m_tail + 1);
        exp_rs1_tag   = m_tag[r1];
        exp_rs2_tag   = m_tag[r2];
        exp_rs1_ready = m_ready[r1];
        exp_rs2_ready = m_ready[r2];
        exp_rs1_value = (r1 == reg_addr_t'(`ZERO_REG)) ? '0 : m_regs[r1];
        exp_rs2_value = (r2 == reg_addr_t'(`ZERO_REG)) ? '0 : m_regs[r2];
        exp_retire_valid = 1'b0;
        exp_retire_dest  = '0;
        exp_retire_value = '0;
        if (m_queue.size() > 0) begin
            head_slot = int'(m_queue[0]) - 1;
            exp_retire_valid = (m_state[head_slot] == ROB_DONE);
            exp_retire_dest  = m_dest[head_slot];
            exp_retire_value = m_value[head_slot];
        end
        if (exp_retire_valid) begin // Commit, clear only a matching mapping
            if (exp_retire_dest == reg_addr_t'(`ZERO_REG)) begin
                zero_retires++;
            end else begin
                m_regs[exp_retire_dest] = exp_retire_value;
                if (m_tag[exp_retire_dest] == m_queue[0]) begin
                    m_tag[exp_retire_dest]   = '0;
                    m_ready[exp_retire_dest] = 1'b0;
                end else begin
                    remap_kept++;
                end
            end
            m_state[head_slot] = ROB_FREE;
            void'(m_queue.pop_front());
        end
        if (cv) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                if ((m_tag[i] != '0) && (m_tag[i] == ct)) begin
                    m_ready[i] = 1'b1;
                end
            end
            cslot = int'(ct) - 1;
            m_state[cslot] = ROB_DONE;
            m_value[cslot] = cval;
        end
        if (dv && exp_stall) begin
            stall_hits++;
        end else if (dv) begin
            m_state[m_tail] = ROB_ISSUED;
            m_dest[m_tail]  = d;
            if (d != reg_addr_t'(`ZERO_REG)) begin
                m_tag[d]   = tag_t'(m_tail + 1);
                m_ready[d] = 1'b0;
            end
            m_queue.push_back(tag_t'(m_tail + 1));
            m_tail = (m_tail + 1) % `ROB_DEPTH;
        end
    endfunction

    // One falling edge of stimulus with percent rates for dispatch and completion
    task automatic drive_cycle(input int dispatch_pct, input int cdb_pct);
        tag_t issued [$];
        int   slot;
        @(negedge clock);
        if (!held) begin
            dispatch_valid = ({$random(seed)} % 100) < dispatch_pct;
            dest_addr      = reg_addr_t'($random(seed) & 32'h7); // Small set forces remaps
            rs1_addr       = reg_addr_t'($random(seed) & 32'h7);
            rs2_addr       = reg_addr_t'($random(seed) & 32'h7);
        end
        foreach (m_queue[i]) begin
            if (m_state[int'(m_queue[i]) - 1] == ROB_ISSUED) begin
                issued.push_back(m_queue[i]);
            end
        end
        if ((issued.size() > 0) && (({$random(seed)} % 100) < cdb_pct)) begin
            cdb_tag   = issued[{$random(seed)} % issued.size()]; // Out of order
            slot      = int'(cdb_tag) - 1;
            cdb_valid = 1'b1;
            cdb_value = (m_dest[slot] == reg_addr_t'(`ZERO_REG)) ? '0 : data_t'($random(seed));
        end else begin
            cdb_valid = 1'b0;
            cdb_tag   = '0;
            cdb_value = '0;
        end
        model_step(dispatch_valid, rs1_addr, rs2_addr, dest_addr, cdb_valid, cdb_tag, cdb_value);
        held = dispatch_valid && exp_stall;
    endtask

    task automatic compare_outputs();
        check_value("dispatch_stall", 32'(dispatch_stall), 32'(exp_stall));
        check_value("dest_tag", 32'(dest_tag), 32'(exp_dest_tag));
        check_value("rs1_tag", 32'(rs1_tag), 32'(exp_rs1_tag));
        check_value("rs2_tag", 32'(rs2_tag), 32'(exp_rs2_tag));
        check_value("rs1_ready", 32'(rs1_ready), 32'(exp_rs1_ready));
        check_value("rs2_ready", 32'(rs2_ready), 32'(exp_rs2_ready));
        check_value("rs1_value", rs1_value, exp_rs1_value);
        check_value("rs2_value", rs2_value, exp_rs2_value);
        check_value("retire_valid", 32'(retire_valid), 32'(exp_retire_valid));
        if (exp_retire_valid) begin
            check_value("retire_dest", 32'(retire_dest), 32'(exp_retire_dest));
            check_value("retire_value", retire_value, exp_retire_value);
        end
    endtask

    // Outputs settle well before mid low phase
    initial begin
        forever begin
            @(negedge clock);
            #5;
            if (check_en) begin
                compare_outputs();
            end
            assert (uut.u_assertions.error_count == 0) else
                stop_with_error("A bound assertion on the DUT failed");
        end
    end

    initial begin
        dispatch_valid = 1'b0;
        rs1_addr       = '0;
        rs2_addr       = '0;
        dest_addr      = '0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        model_reset();

        waited = 0;
        do begin
            @(posedge clock);
            waited++;
            if (waited > RESET_LIMIT) begin
                stop_with_error("Timeout waiting for reset to be released");
            end
        end while (reset);
        check_en = 1'b1;

        repeat (40) drive_cycle(90, 10);  // Fill the buffer
        repeat (400) drive_cycle(60, 50);
        repeat (40) drive_cycle(95, 15);

        waited = 0;
        while ((m_queue.size() != 0) || held) begin
            drive_cycle(0, 70);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                stop_with_error("Timeout waiting for the reorder buffer to drain");
            end
        end
        drive_cycle(0, 0);
        #10;

        assert (stall_hits > 0) else stop_with_error("Full reorder buffer was never reached");
        assert (remap_kept > 0) else stop_with_error("No newer mapping outlived a retirement");
        assert (zero_retires > 0) else stop_with_error("No register zero instruction retired");

        if (uut.u_assertions.error_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            stop_with_error("A bound assertion on the DUT failed");
        end
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+rtl
rtl/rename_pkg.sv
rtl/rename_if.sv
rtl/map_table.sv
rtl/reorder_buffer.sv
rtl/arch_reg_file.sv
rtl/rename_core.sv
tb/rename_core_assertions.sv
tb/rename_core_tb.sv

/* Bender.yml */
package:
  name: rename_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rename_pkg.sv
      - rtl/rename_if.sv
      - rtl/map_table.sv
      - rtl/reorder_buffer.sv
      - rtl/arch_reg_file.sv
      - rtl/rename_core.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tb/rename_core_assertions.sv
      - tb/rename_core_tb.sv
